// File: logic/trace_defs.svh
// Trace unit widths, record FIFO depth and record size
// Bit offsets of the traced mstatus, mie and mip fields
`ifndef TRACE_DEFS_SVH
`define TRACE_DEFS_SVH

`define TRACE_XLEN          32
`define TRACE_REG_AW        5
`define TRACE_FIFO_DEPTH    4
`define TRACE_ENTRY_MAX     4
`define TRACE_EC_W          4

// Time, event, pc, instr, npc, count, reg index, payload slots
`define TRACE_REC_W (4*`TRACE_XLEN + 2 + 3 + `TRACE_REG_AW + `TRACE_ENTRY_MAX*`TRACE_XLEN)

// mstatus fields
`define TRACE_MIE_BIT       3
`define TRACE_MPIE_BIT      7
`define TRACE_MPP_LSB       11

// Same offsets in mie and mip
`define TRACE_MSI_BIT       3
`define TRACE_MTI_BIT       7
`define TRACE_MEI_BIT       11

`endif

// File: logic/trace_pkg.sv
// Vector types of the trace unit
// Event class and entry tag enums
`include "trace_defs.svh"

package trace_pkg;

    typedef logic [`TRACE_XLEN-1:0]     xword_t;
    typedef logic [`TRACE_REG_AW-1:0]   reg_idx_t;
    typedef logic [`TRACE_XLEN-1:0]     cycle_t;
    typedef logic [2:0]                 entry_cnt_t;    // 1 to 4 entries
    typedef logic [`TRACE_REC_W-1:0]    trace_rec_t;

    // Event class of one record
    typedef enum logic [1:0] {
        EV_NONE = 2'd0,
        EV_EXC  = 2'd1,
        EV_IRQ  = 2'd2,
        EV_WAKE = 2'd3
    } trace_event_e;

    // Register reported by one entry
    typedef enum logic [2:0] {
        TAG_NONE    = 3'd0,
        TAG_GPR     = 3'd1,
        TAG_MSTATUS = 3'd2,
        TAG_MEPC    = 3'd3,
        TAG_MCAUSE  = 3'd4,
        TAG_MTVAL   = 3'd5,
        TAG_MIP     = 3'd6,
        TAG_MIE     = 3'd7
    } entry_tag_e;

endpackage

// File: logic/trace_csr_pack.sv
// CSR word assembly from the core's loose status and interrupt bits
`timescale 1ns/10ps
`include "trace_defs.svh"

module trace_csr_pack import trace_pkg::*; (
    input  logic                    csr_mie_i,
    input  logic                    csr_mpie_i,
    input  logic                    csr_meie_i,
    input  logic                    csr_mtie_i,
    input  logic                    csr_msie_i,
    input  logic                    csr_meip_i,
    input  logic                    csr_mtip_i,
    input  logic                    csr_msip_i,
    input  logic [`TRACE_XLEN-1:1]  csr_mepc_i,         // Bit 0 always zero with RVC
    input  logic                    csr_mcause_irq_i,
    input  logic [`TRACE_EC_W-1:0]  csr_mcause_ec_i,
    input  xword_t                  csr_mtval_i,
    output xword_t                  mstatus_o,
    output xword_t                  mepc_o,
    output xword_t                  mcause_o,
    output xword_t                  mtval_o,
    output xword_t                  mip_o,
    output xword_t                  mie_o
);

    assign mepc_o   = {csr_mepc_i, 1'b0};
    assign mcause_o = {csr_mcause_irq_i, {(`TRACE_XLEN-1-`TRACE_EC_W){1'b0}}, csr_mcause_ec_i};
    assign mtval_o  = csr_mtval_i;

    always_comb begin
        mstatus_o = '0;
        mie_o     = '0;
        mip_o     = '0;

        mstatus_o[`TRACE_MIE_BIT]                    = csr_mie_i;
        mstatus_o[`TRACE_MPIE_BIT]                   = csr_mpie_i;
        mstatus_o[`TRACE_MPP_LSB+1:`TRACE_MPP_LSB]   = 2'b11;  // Machine mode only

        mie_o[`TRACE_MSI_BIT] = csr_msie_i;
        mie_o[`TRACE_MTI_BIT] = csr_mtie_i;
        mie_o[`TRACE_MEI_BIT] = csr_meie_i;
        mip_o[`TRACE_MSI_BIT] = csr_msip_i;
        mip_o[`TRACE_MTI_BIT] = csr_mtip_i;
        mip_o[`TRACE_MEI_BIT] = csr_meip_i;
    end

endmodule

// File: logic/trace_capture.sv
// Cycle counter, event classification and next-PC tracking
// Assembles one flat trace record per update cycle
`timescale 1ns/10ps
`include "trace_defs.svh"

module trace_capture import trace_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pc_update_i,
    input  xword_t      pc_next_i,
    input  xword_t      instr_i,
    input  logic        gpr_wr_i,
    input  reg_idx_t    gpr_addr_i,
    input  xword_t      gpr_data_i,
    input  logic        exc_i,
    input  logic        irq_i,
    input  logic        wake_i,
    input  xword_t      mstatus_i,
    input  xword_t      mepc_i,
    input  xword_t      mcause_i,
    input  xword_t      mtval_i,
    input  xword_t      mip_i,
    input  xword_t      mie_i,
    output logic        push_o,
    output trace_rec_t  rec_o
);

    localparam int XW    = `TRACE_XLEN;
    localparam int PAY_W = `TRACE_ENTRY_MAX * `TRACE_XLEN;

    logic               update;
    cycle_t             cyc_q;
    xword_t             npc_q;          // Becomes the current PC of the next record
    trace_event_e       ev;
    entry_cnt_t         cnt;
    reg_idx_t           idx;
    logic [PAY_W-1:0]   payload;

    assign update = pc_update_i | gpr_wr_i;

    // --------------------------------------------------
    // Event class and payload slots
    // --------------------------------------------------
    always_comb begin
        if (exc_i)       ev = EV_EXC;
        else if (irq_i)  ev = EV_IRQ;
        else if (wake_i) ev = EV_WAKE;
        else             ev = EV_NONE;
    end

    always_comb begin
        cnt     = entry_cnt_t'(1);
        idx     = '0;
        payload = '0;
        case (ev)
            EV_EXC, EV_IRQ: begin
                cnt                 = entry_cnt_t'(`TRACE_ENTRY_MAX);
                payload[0*XW +: XW] = mstatus_i;
                payload[1*XW +: XW] = mepc_i;
                payload[2*XW +: XW] = mcause_i;
                payload[3*XW +: XW] = mtval_i;
            end
            EV_WAKE: begin
                if ((mip_i & mie_i) != '0) begin   // Pending and enabled
                    cnt                 = entry_cnt_t'(2);
                    payload[0*XW +: XW] = mip_i;
                    payload[1*XW +: XW] = mie_i;
                end
            end
            default: begin
                if (gpr_wr_i && gpr_addr_i != '0) begin
                    idx                 = gpr_addr_i;
                    payload[0*XW +: XW] = gpr_data_i;
                end
            end
        endcase
    end

    // --------------------------------------------------
    // Counter, PC chain and record register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cyc_q  <= '0;
            npc_q  <= '0;
            push_o <= 1'b0;
        end else begin
            cyc_q  <= cyc_q + 1'b1;     // Free running
            push_o <= update;
            if (update) npc_q <= pc_next_i;
        end
    end

    always_ff @(posedge clk) begin
        if (update) rec_o <= {cyc_q, ev, npc_q, instr_i, pc_next_i, cnt, idx, payload};
    end

endmodule

// File: logic/trace_fifo.sv
// Circular record FIFO with sticky overflow flag
`timescale 1ns/10ps
`include "trace_defs.svh"

module trace_fifo import trace_pkg::*; #(
    parameter int DEPTH = `TRACE_FIFO_DEPTH
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push_i,
    input  trace_rec_t  rec_i,
    input  logic        pop_i,
    output trace_rec_t  rec_o,
    output logic        nonempty_o,
    output logic        overflow_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    trace_rec_t         mem [DEPTH];
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    logic [CW-1:0]      count;
    logic               full;
    logic               wr_en;
    logic               rd_en;

    assign full       = (count == CW'(DEPTH));
    assign wr_en      = push_i & ~full;     // Push on full is dropped
    assign rd_en      = pop_i & nonempty_o;
    assign nonempty_o = (count != '0);
    assign rec_o      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (wr_en) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (wr_en && !rd_en)      count <= count + 1'b1;
            else if (!wr_en && rd_en) count <= count - 1'b1;
            if (push_i && full) overflow_o <= 1'b1;     // Held until reset
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= rec_i;
    end

endmodule

// File: logic/trace_emit.sv
// Record serializer emitting one tagged trace entry per cycle
// Tag lookup from event class, slot and stored count
`timescale 1ns/10ps
`include "trace_defs.svh"

module trace_emit import trace_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            nonempty_i,
    input  trace_rec_t      rec_i,
    output logic            pop_o,
    output logic            entry_valid_o,
    output cycle_t          entry_time_o,
    output trace_event_e    entry_event_o,
    output xword_t          entry_pc_o,
    output xword_t          entry_instr_o,
    output xword_t          entry_npc_o,
    output entry_tag_e      entry_tag_o,
    output reg_idx_t        entry_reg_o,
    output xword_t          entry_value_o
);

    localparam int XW    = `TRACE_XLEN;
    localparam int PAY_W = `TRACE_ENTRY_MAX * `TRACE_XLEN;

    trace_rec_t         cur_rec;
    logic               busy_q;
    entry_cnt_t         slot_q;
    logic               last;

    cycle_t             cur_time;
    logic [1:0]         cur_ev;
    xword_t             cur_pc;
    xword_t             cur_instr;
    xword_t             cur_npc;
    entry_cnt_t         cur_cnt;
    reg_idx_t           cur_idx;
    logic [PAY_W-1:0]   cur_pay;

    // Fixed tag table
    function automatic entry_tag_e tag_lookup(trace_event_e ev, entry_cnt_t slot,
                                              entry_cnt_t cnt, reg_idx_t idx);
        entry_tag_e tag;
        tag = TAG_NONE;
        case (ev)
            EV_EXC, EV_IRQ: begin
                case (slot)
                    3'd0:    tag = TAG_MSTATUS;
                    3'd1:    tag = TAG_MEPC;
                    3'd2:    tag = TAG_MCAUSE;
                    default: tag = TAG_MTVAL;
                endcase
            end
            EV_WAKE: if (cnt == 3'd2) tag = (slot == 3'd0) ? TAG_MIP : TAG_MIE;
            default: if (idx != '0) tag = TAG_GPR;
        endcase
        return tag;
    endfunction

    assign {cur_time, cur_ev, cur_pc, cur_instr, cur_npc, cur_cnt, cur_idx, cur_pay} = cur_rec;

    assign last  = busy_q && ((slot_q + 1'b1) == cur_cnt);
    assign pop_o = nonempty_i & (~busy_q | last);     // Back-to-back records

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            slot_q <= '0;
        end else if (pop_o) begin
            busy_q <= 1'b1;
            slot_q <= '0;
        end else if (last) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            slot_q <= slot_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) cur_rec <= rec_i;
    end

    // Common columns repeat on every entry
    assign entry_valid_o = busy_q;
    assign entry_time_o  = cur_time;
    assign entry_event_o = trace_event_e'(cur_ev);
    assign entry_pc_o    = cur_pc;
    assign entry_instr_o = cur_instr;
    assign entry_npc_o   = cur_npc;
    assign entry_tag_o   = tag_lookup(trace_event_e'(cur_ev), slot_q, cur_cnt, cur_idx);
    assign entry_reg_o   = cur_idx;
    assign entry_value_o = cur_pay[slot_q*XW +: XW];

endmodule

// File: logic/trace_top.sv
// Trace unit top level
// CSR packing, capture, record FIFO and entry emitter
`timescale 1ns/10ps

module trace_top import trace_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    // Core side
    input  logic                        pc_update_i,
    input  xword_t                      pc_next_i,
    input  xword_t                      instr_i,
    input  logic                        gpr_wr_i,
    input  reg_idx_t                    gpr_addr_i,
    input  xword_t                      gpr_data_i,
    input  logic                        csr_mie_i,
    input  logic                        csr_mpie_i,
    input  logic                        csr_meie_i,
    input  logic                        csr_mtie_i,
    input  logic                        csr_msie_i,
    input  logic                        csr_meip_i,
    input  logic                        csr_mtip_i,
    input  logic                        csr_msip_i,
    input  logic [$bits(xword_t)-1:1]   csr_mepc_i,
    input  logic                        csr_mcause_irq_i,
    input  logic [3:0]                  csr_mcause_ec_i,    // Exception code
    input  xword_t                      csr_mtval_i,
    input  logic                        exc_i,
    input  logic                        irq_i,
    input  logic                        wake_i,
    // Trace entries
    output logic                        entry_valid_o,
    output cycle_t                      entry_time_o,
    output trace_event_e                entry_event_o,
    output xword_t                      entry_pc_o,
    output xword_t                      entry_instr_o,
    output xword_t                      entry_npc_o,
    output entry_tag_e                  entry_tag_o,
    output reg_idx_t                    entry_reg_o,
    output xword_t                      entry_value_o,
    output logic                        overflow_o
);

    xword_t         mstatus, mepc, mcause, mtval, mip, mie;
    logic           push, pop, nonempty;
    trace_rec_t     cap_rec, head_rec;

    trace_csr_pack u_csr_pack (
        .csr_mie_i, .csr_mpie_i, .csr_meie_i, .csr_mtie_i, .csr_msie_i,
        .csr_meip_i, .csr_mtip_i, .csr_msip_i, .csr_mepc_i,
        .csr_mcause_irq_i, .csr_mcause_ec_i, .csr_mtval_i,
        .mstatus_o(mstatus), .mepc_o(mepc), .mcause_o(mcause),
        .mtval_o(mtval), .mip_o(mip), .mie_o(mie)
    );

    trace_capture u_capture (
        .clk, .rst_n, .pc_update_i, .pc_next_i, .instr_i,
        .gpr_wr_i, .gpr_addr_i, .gpr_data_i, .exc_i, .irq_i, .wake_i,
        .mstatus_i(mstatus), .mepc_i(mepc), .mcause_i(mcause),
        .mtval_i(mtval), .mip_i(mip), .mie_i(mie),
        .push_o(push), .rec_o(cap_rec)
    );

    trace_fifo u_fifo (
        .clk, .rst_n, .push_i(push), .rec_i(cap_rec), .pop_i(pop),
        .rec_o(head_rec), .nonempty_o(nonempty), .overflow_o
    );

    trace_emit u_emit (
        .clk, .rst_n, .nonempty_i(nonempty), .rec_i(head_rec), .pop_o(pop),
        .entry_valid_o, .entry_time_o, .entry_event_o, .entry_pc_o,
        .entry_instr_o, .entry_npc_o, .entry_tag_o, .entry_reg_o, .entry_value_o
    );

endmodule

// File: bench/trace_tb.sv
// Testbench for the trace unit
// Reference model, entry scoreboard with assertions, watchdog
`timescale 1ns/10ps
`include "trace_defs.svh"

module trace_tb import trace_pkg::*; ();

    localparam int CLK_PERIOD       = 40;
    localparam int RESET_CYCLES     = 5;
    localparam int IDLE_CYCLES      = 20;
    localparam int GAP              = 5;        // Idle cycles after each spaced update
    localparam int DIRECTED_UPDATES = 13;
    localparam int RANDOM_UPDATES   = 40;
    localparam int BURST_UPDATES    = 20;
    localparam int DRAIN_WAITS      = 5;
    localparam int DRAIN_CYCLES     = 30;       // Worst case per drain wait
    localparam int TEST_CYCLES      = 2*RESET_CYCLES + 3*IDLE_CYCLES + BURST_UPDATES
                                    + (DIRECTED_UPDATES + RANDOM_UPDATES) * (GAP + 1)
                                    + DRAIN_WAITS * DRAIN_CYCLES;
    localparam int WATCHDOG_CYCLES  = TEST_CYCLES + TEST_CYCLES / 2;
    // Time, event, pc, instr, npc, tag, reg index, value
    localparam int EXP_W            = 5*`TRACE_XLEN + 2 + 3 + `TRACE_REG_AW;

    logic                       clk;
    logic                       rst_n;
    logic                       pc_update, gpr_wr, exc, irq, wake;
    xword_t                     pc_next, instr, gpr_data, csr_mtval;
    reg_idx_t                   gpr_addr;
    logic                       csr_mie, csr_mpie, csr_meie, csr_mtie, csr_msie;
    logic                       csr_meip, csr_mtip, csr_msip, csr_mcause_irq;
    logic [`TRACE_XLEN-1:1]     csr_mepc;
    logic [`TRACE_EC_W-1:0]     csr_mcause_ec;

    logic                       entry_valid_o, overflow_o;
    cycle_t                     entry_time_o;
    trace_event_e               entry_event_o;
    xword_t                     entry_pc_o, entry_instr_o, entry_npc_o, entry_value_o;
    entry_tag_e                 entry_tag_o;
    reg_idx_t                   entry_reg_o;

    // Reference model state
    int                         seed;
    cycle_t                     cyc;
    xword_t                     model_pc;
    trace_event_e               rec_ev;
    xword_t                     rec_pc;
    logic [EXP_W-1:0]           exp_q [$];
    logic                       first_q [$];    // Marks the first entry of each record
    logic                       drop_ok, ovf_allowed, ovf_seen;
    int                         checked;
    logic [EXP_W-1:0]           got;

    trace_top u_trace_top (
        .clk(clk), .rst_n(rst_n), .pc_update_i(pc_update), .pc_next_i(pc_next),
        .instr_i(instr), .gpr_wr_i(gpr_wr), .gpr_addr_i(gpr_addr), .gpr_data_i(gpr_data),
        .csr_mie_i(csr_mie), .csr_mpie_i(csr_mpie), .csr_meie_i(csr_meie),
        .csr_mtie_i(csr_mtie), .csr_msie_i(csr_msie), .csr_meip_i(csr_meip),
        .csr_mtip_i(csr_mtip), .csr_msip_i(csr_msip), .csr_mepc_i(csr_mepc),
        .csr_mcause_irq_i(csr_mcause_irq), .csr_mcause_ec_i(csr_mcause_ec),
        .csr_mtval_i(csr_mtval), .exc_i(exc), .irq_i(irq), .wake_i(wake),
        .entry_valid_o(entry_valid_o), .entry_time_o(entry_time_o),
        .entry_event_o(entry_event_o), .entry_pc_o(entry_pc_o),
        .entry_instr_o(entry_instr_o), .entry_npc_o(entry_npc_o),
        .entry_tag_o(entry_tag_o), .entry_reg_o(entry_reg_o),
        .entry_value_o(entry_value_o), .overflow_o(overflow_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // --------------------------------------------------
    // Failure reporting
    // --------------------------------------------------
    task automatic abort_run;
        $display("TEST FAILED");
        $fatal;
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        abort_run;
    endtask

    task automatic report_mismatch(input logic [EXP_W-1:0] exp, input logic [EXP_W-1:0] act);
        $display("error at %0d ns: trace entry mismatch, expected %h got %h", $time, exp, act);
        abort_run;
    endtask

    // --------------------------------------------------
    // Stimulus and reference model
    // --------------------------------------------------
    task automatic step;
        @(posedge clk);
        #2;
        cyc = cyc + 1;      // Counter value seen by the next sampling edge
    endtask

    task automatic apply_reset;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) step;
        rst_n    = 1'b1;
        cyc      = '0;
        model_pc = '0;
    endtask

    task automatic set_csr_random;
        xword_t r;
        xword_t r2;
        r              = $random(seed);
        r2             = $random(seed);
        csr_mie        = r[0];
        csr_mpie       = r[1];
        csr_meie       = r[2];
        csr_mtie       = r[3];
        csr_msie       = r[4];
        csr_meip       = r[5];
        csr_mtip       = r[6];
        csr_msip       = r[7];
        csr_mcause_irq = r[8];
        csr_mcause_ec  = r[12:9];
        csr_mepc       = r2[31:1];
        csr_mtval      = $random(seed);
    endtask

    task automatic add_entry(input entry_tag_e tag, input reg_idx_t idx, input xword_t val,
                             input logic first);
        exp_q.push_back({cyc, rec_ev, rec_pc, instr, pc_next, tag, idx, val});
        first_q.push_back(first);
    endtask

    task automatic do_update(input logic pcu, input logic gw, input reg_idx_t addr,
                             input logic ev_exc, input logic ev_irq, input logic ev_wake,
                             input int gap);
        xword_t mst;
        xword_t mca;
        xword_t pend;
        xword_t ena;
        pc_update = pcu;
        gpr_wr    = gw;
        gpr_addr  = addr;
        gpr_data  = $random(seed);
        pc_next   = $random(seed);
        instr     = $random(seed);
        exc       = ev_exc;
        irq       = ev_irq;
        wake      = ev_wake;

        // Architectural CSR words
        mst                       = '0;
        mst[`TRACE_MIE_BIT]       = csr_mie;
        mst[`TRACE_MPIE_BIT]      = csr_mpie;
        mst[`TRACE_MPP_LSB]       = 1'b1;
        mst[`TRACE_MPP_LSB+1]     = 1'b1;
        mca                       = '0;
        mca[`TRACE_XLEN-1]        = csr_mcause_irq;
        mca[`TRACE_EC_W-1:0]      = csr_mcause_ec;
        pend                      = '0;
        pend[`TRACE_MSI_BIT]      = csr_msip;
        pend[`TRACE_MTI_BIT]      = csr_mtip;
        pend[`TRACE_MEI_BIT]      = csr_meip;
        ena                       = '0;
        ena[`TRACE_MSI_BIT]       = csr_msie;
        ena[`TRACE_MTI_BIT]       = csr_mtie;
        ena[`TRACE_MEI_BIT]       = csr_meie;

        if (ev_exc)       rec_ev = EV_EXC;
        else if (ev_irq)  rec_ev = EV_IRQ;
        else if (ev_wake) rec_ev = EV_WAKE;
        else              rec_ev = EV_NONE;

        if (pcu || gw) begin
            rec_pc   = model_pc;
            model_pc = pc_next;
            case (rec_ev)
                EV_EXC, EV_IRQ: begin
                    add_entry(TAG_MSTATUS, '0, mst, 1'b1);
                    add_entry(TAG_MEPC, '0, {csr_mepc, 1'b0}, 1'b0);
                    add_entry(TAG_MCAUSE, '0, mca, 1'b0);
                    add_entry(TAG_MTVAL, '0, csr_mtval, 1'b0);
                end
                EV_WAKE: begin
                    if ((pend & ena) != '0) begin
                        add_entry(TAG_MIP, '0, pend, 1'b1);
                        add_entry(TAG_MIE, '0, ena, 1'b0);
                    end else begin
                        add_entry(TAG_NONE, '0, '0, 1'b1);
                    end
                end
                default: begin
                    if (gw && addr != '0) add_entry(TAG_GPR, addr, gpr_data, 1'b1);
                    else                  add_entry(TAG_NONE, '0, '0, 1'b1);
                end
            endcase
        end
        step;
        pc_update = 1'b0;
        gpr_wr    = 1'b0;
        exc       = 1'b0;
        irq       = 1'b0;
        wake      = 1'b0;
        repeat (gap) step;
    endtask

    task automatic wait_idle;
        int quiet;
        quiet = 0;
        while (quiet < 8) begin
            step;
            if (entry_valid_o) quiet = 0;
            else               quiet = quiet + 1;
        end
    endtask

    task automatic check_drained;
        assert (exp_q.size() == 0) else report_problem("expected trace entries were not emitted");
    endtask

    task automatic skip_record;
        void'(exp_q.pop_front());
        void'(first_q.pop_front());
        while (exp_q.size() > 0 && !first_q[0]) begin
            void'(exp_q.pop_front());
            void'(first_q.pop_front());
        end
    endtask

    // --------------------------------------------------
    // Scoreboard sampled mid cycle
    // --------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (overflow_o) ovf_seen = 1'b1;
            assert (ovf_allowed || !overflow_o)
                else report_problem("overflow flag set while the FIFO could not fill");
            assert (!ovf_seen || overflow_o)
                else report_problem("overflow flag cleared before reset");
            if (entry_valid_o) begin
                got = {entry_time_o, entry_event_o, entry_pc_o, entry_instr_o, entry_npc_o,
                       entry_tag_o, entry_reg_o, entry_value_o};
                // Dropped records vanish whole
                while (drop_ok && exp_q.size() > 0 && first_q[0] && exp_q[0] !== got)
                    skip_record;
                assert (exp_q.size() > 0)
                    else report_problem("trace entry emitted with no expected record");
                if (exp_q.size() > 0) begin
                    assert (exp_q[0] === got) else report_mismatch(exp_q[0], got);
                    void'(exp_q.pop_front());
                    void'(first_q.pop_front());
                    checked = checked + 1;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_problem("watchdog timeout, the tests did not complete in time");
    end

    initial begin
        xword_t r;
        int     burst_start;
        seed = 32'h8589_ff8f;
        {pc_update, gpr_wr, exc, irq, wake} = '0;
        {pc_next, instr, gpr_data, gpr_addr} = '0;
        {csr_mie, csr_mpie, csr_meie, csr_mtie, csr_msie} = '0;
        {csr_meip, csr_mtip, csr_msip, csr_mcause_irq} = '0;
        {csr_mepc, csr_mcause_ec, csr_mtval} = '0;
        {drop_ok, ovf_allowed, ovf_seen} = '0;
        checked = 0;
        apply_reset;
        repeat (IDLE_CYCLES) step;      // Quiet after reset

        // Register writes, address 0 and PC-only updates
        set_csr_random;
        for (int k = 0; k < 4; k++) do_update(1'b1, 1'b1, reg_idx_t'(k*7 + 3), 0, 0, 0, GAP);
        do_update(1'b0, 1'b1, 5'd31, 1'b0, 1'b0, 1'b0, GAP);
        do_update(1'b1, 1'b1, 5'd0, 1'b0, 1'b0, 1'b0, GAP);
        do_update(1'b1, 1'b0, 5'd9, 1'b0, 1'b0, 1'b0, GAP);
        wait_idle;
        check_drained;

        // Exception, interrupt and both at once
        set_csr_random;
        do_update(1'b1, 1'b1, 5'd4, 1'b1, 1'b0, 1'b0, GAP);
        set_csr_random;
        do_update(1'b1, 1'b0, 5'd0, 1'b0, 1'b1, 1'b0, GAP);
        set_csr_random;
        do_update(1'b1, 1'b0, 5'd0, 1'b1, 1'b1, 1'b0, GAP);
        set_csr_random;
        do_update(1'b1, 1'b0, 5'd0, 1'b0, 1'b1, 1'b1, GAP);
        wait_idle;
        check_drained;

        // Wakeup with and without a pending enabled interrupt
        set_csr_random;
        csr_mtie = 1'b1;
        csr_mtip = 1'b1;
        do_update(1'b1, 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, GAP);
        {csr_meip, csr_mtip, csr_msip} = '0;
        do_update(1'b1, 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, GAP);
        wait_idle;
        check_drained;

        // Random spaced updates
        for (int k = 0; k < RANDOM_UPDATES; k++) begin
            r = $random(seed);
            set_csr_random;
            do_update(r[0], r[1] | ~r[0], r[8:4], r[11:9] == 3'd1,
                      r[11:9] == 3'd2 || (r[11:9] == 3'd1 && r[12]),
                      r[11:9] == 3'd3 || (r[11:9] == 3'd2 && r[13]), GAP);
        end
        wait_idle;
        check_drained;

        // Back-to-back exceptions overrun the record FIFO
        ovf_allowed = 1'b1;
        drop_ok     = 1'b1;
        burst_start = checked;
        for (int k = 0; k < BURST_UPDATES; k++) begin
            set_csr_random;
            do_update(1'b1, 1'b0, 5'd0, 1'b1, 1'b0, 1'b0, 0);
        end
        wait_idle;
        // Emitter and FIFO hold the first records of the burst
        assert (checked - burst_start >= (`TRACE_FIFO_DEPTH + 1) * `TRACE_ENTRY_MAX)
            else report_problem("records lost from the burst before the record FIFO was full");
        assert (ovf_seen && overflow_o)
            else report_problem("overflow flag not set by a full record FIFO");
        exp_q.delete();
        first_q.delete();
        repeat (IDLE_CYCLES) step;      // Flag must hold

        apply_reset;
        {drop_ok, ovf_allowed, ovf_seen} = '0;
        repeat (IDLE_CYCLES) step;
        if (checked > 0 && !overflow_o && !entry_valid_o) begin
            $display("TEST OK");
            $finish;
        end else begin
            report_problem("trace unit not idle after the final reset");
        end
    end

endmodule

// File: flist.f
+incdir+logic
logic/trace_pkg.sv
logic/trace_csr_pack.sv
logic/trace_capture.sv
logic/trace_fifo.sv
logic/trace_emit.sv
logic/trace_top.sv
bench/trace_tb.sv

// File: run.sh
#!/bin/sh
# Build the trace unit testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module trace_tb -o trace_sim &&
./obj_dir/trace_sim > sim.log 2>&1
grep -q "^TEST OK$" sim.log && echo "simulation passed" || { cat sim.log; exit 1; }
